//--- Makefile
# Verilator flow for the CSR execute slice

VERILATOR ?= verilator
TB_TOP    ?= tb_csr_subsys
RTL_TOP   ?= csr_subsys_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the pass line shows up in the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
design/csr_pkg.sv
design/exu_csr_unit.sv
design/csr_regfile.sv
design/csr_subsys_top.sv
tests/tb_csr_subsys.sv

//--- design/csr_pkg.sv
package csr_pkg;

    // datapath widths
    localparam int XLEN        = 32;
    localparam int CSR_ADDR_W  = 12;
    localparam int REG_ADDR_W  = 5;
    localparam int COMMIT_ID_W = 4;

    // csr instruction flavour, 2'b11 means no write
    typedef enum logic [1:0] {
        CSR_RW = 2'b00,  // csrrw, operand replaces csr
        CSR_RS = 2'b01,  // csrrs, operand bits set
        CSR_RC = 2'b10   // csrrc, operand bits cleared
    } csr_op_e;

    // machine mode csr addresses
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS  = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE      = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MHARTID  = 12'hF14;

    // writable bits
    localparam logic [XLEN-1:0] MSTATUS_WMASK = 32'h0000_1888;  // mpp, mpie, mie
    localparam logic [XLEN-1:0] MTVEC_WMASK   = 32'hFFFF_FFFC;  // base only, mode stays 0
    localparam logic [XLEN-1:0] MEPC_WMASK    = 32'hFFFF_FFFE;  // bit 0 always zero

    // writable mask per address
    // zero means the csr takes no write at all (mhartid, unknown)
    function automatic logic [XLEN-1:0] csr_wmask(input logic [CSR_ADDR_W-1:0] addr);
        logic [XLEN-1:0] mask;
        case (addr)
            CSR_MSTATUS:  mask = MSTATUS_WMASK;
            CSR_MIE:      mask = '1;
            CSR_MTVEC:    mask = MTVEC_WMASK;
            CSR_MSCRATCH: mask = '1;
            CSR_MEPC:     mask = MEPC_WMASK;
            CSR_MCAUSE:   mask = '1;
            default:      mask = '0;  // read only or not implemented
        endcase
        return mask;
    endfunction

endpackage

//--- design/csr_regfile.sv
module csr_regfile #(
    parameter logic [31:0] HART_ID = 32'd0
) (
    input  logic                          clk,
    input  logic                          arst_n_i,

    // combinational read port
    input  logic [csr_pkg::CSR_ADDR_W-1:0] raddr_i,
    output logic [csr_pkg::XLEN-1:0]       rdata_o,

    // write port, lands on the edge
    input  logic                          we_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] waddr_i,
    input  logic [csr_pkg::XLEN-1:0]       wdata_i
);

    import csr_pkg::*;

    logic [XLEN-1:0] mstatus_q;
    logic [XLEN-1:0] mie_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mscratch_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;

    logic [XLEN-1:0] wmask;   // writable bits of the target
    logic [XLEN-1:0] wbits;   // masked write data

    assign wmask = csr_wmask(waddr_i);
    assign wbits = wdata_i & wmask;

    // masked merge per register
    // non-writable bits come from reset and stay zero
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mstatus_q  <= '0;
            mie_q      <= '0;
            mtvec_q    <= '0;  // direct mode, base 0
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else if (we_i) begin
            case (waddr_i)
                CSR_MSTATUS: begin
                    mstatus_q <= (mstatus_q & ~wmask) | wbits;
                end
                CSR_MIE: begin
                    mie_q <= (mie_q & ~wmask) | wbits;
                end
                CSR_MTVEC: begin
                    mtvec_q <= (mtvec_q & ~wmask) | wbits;
                end
                CSR_MSCRATCH: begin
                    mscratch_q <= (mscratch_q & ~wmask) | wbits;
                end
                CSR_MEPC: begin
                    mepc_q <= (mepc_q & ~wmask) | wbits;
                end
                CSR_MCAUSE: begin
                    mcause_q <= (mcause_q & ~wmask) | wbits;
                end
                default: begin
                    // mhartid and unknown addresses drop the write
                end
            endcase
        end
    end

    // read mux
    always_comb begin
        case (raddr_i)
            CSR_MSTATUS:  rdata_o = mstatus_q;
            CSR_MIE:      rdata_o = mie_q;
            CSR_MTVEC:    rdata_o = mtvec_q;
            CSR_MSCRATCH: rdata_o = mscratch_q;
            CSR_MEPC:     rdata_o = mepc_q;
            CSR_MCAUSE:   rdata_o = mcause_q;
            CSR_MHARTID:  rdata_o = HART_ID;  // fixed per hart
            default:      rdata_o = '0;       // unimplemented reads zero
        endcase
    end

endmodule

//--- design/csr_subsys_top.sv
module csr_subsys_top #(
    parameter logic [31:0] HART_ID = 32'd0
) (
    input  logic                           clk,
    input  logic                           arst_n_i,

    // issue
    input  logic                           req_valid_i,
    output logic                           req_ready_o,
    input  csr_pkg::csr_op_e               req_op_i,
    input  logic [csr_pkg::XLEN-1:0]        req_op1_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  req_csr_addr_i,
    input  logic [csr_pkg::REG_ADDR_W-1:0]  req_rd_i,
    input  logic                           req_rd_we_i,
    input  logic [csr_pkg::COMMIT_ID_W-1:0] req_commit_id_i,

    input  logic                           int_assert_i,

    // writeback
    output logic                           wb_valid_o,
    input  logic                           wb_ready_i,
    output logic [csr_pkg::REG_ADDR_W-1:0]  wb_rd_o,
    output logic [csr_pkg::XLEN-1:0]        wb_data_o,
    output logic [csr_pkg::COMMIT_ID_W-1:0] wb_commit_id_o
);

    import csr_pkg::*;

    // unit to register block
    logic [CSR_ADDR_W-1:0] csr_raddr;
    logic [XLEN-1:0]       csr_rdata;
    logic                  csr_we;
    logic [CSR_ADDR_W-1:0] csr_waddr;
    logic [XLEN-1:0]       csr_wdata;

    exu_csr_unit u_exu_csr (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .req_op_i        (req_op_i),
        .req_op1_i       (req_op1_i),
        .req_csr_addr_i  (req_csr_addr_i),
        .req_rd_i        (req_rd_i),
        .req_rd_we_i     (req_rd_we_i),
        .req_commit_id_i (req_commit_id_i),
        .int_assert_i    (int_assert_i),
        .csr_raddr_o     (csr_raddr),
        .csr_rdata_i     (csr_rdata),
        .csr_we_o        (csr_we),
        .csr_waddr_o     (csr_waddr),
        .csr_wdata_o     (csr_wdata),
        .wb_valid_o      (wb_valid_o),
        .wb_ready_i      (wb_ready_i),
        .wb_rd_o         (wb_rd_o),
        .wb_data_o       (wb_data_o),
        .wb_commit_id_o  (wb_commit_id_o)
    );

    // machine csr storage
    csr_regfile #(
        .HART_ID (HART_ID)
    ) u_csr_regfile (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .raddr_i  (csr_raddr),
        .rdata_o  (csr_rdata),
        .we_i     (csr_we),
        .waddr_i  (csr_waddr),
        .wdata_i  (csr_wdata)
    );

endmodule

//--- design/exu_csr_unit.sv
module exu_csr_unit (
    input  logic                           clk,
    input  logic                           arst_n_i,

    // issue side
    input  logic                           req_valid_i,
    output logic                           req_ready_o,
    input  csr_pkg::csr_op_e               req_op_i,
    input  logic [csr_pkg::XLEN-1:0]        req_op1_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  req_csr_addr_i,
    input  logic [csr_pkg::REG_ADDR_W-1:0]  req_rd_i,
    input  logic                           req_rd_we_i,
    input  logic [csr_pkg::COMMIT_ID_W-1:0] req_commit_id_i,

    input  logic                           int_assert_i,  // kills the issuing instr

    // csr register block
    output logic [csr_pkg::CSR_ADDR_W-1:0]  csr_raddr_o,
    input  logic [csr_pkg::XLEN-1:0]        csr_rdata_i,
    output logic                           csr_we_o,
    output logic [csr_pkg::CSR_ADDR_W-1:0]  csr_waddr_o,
    output logic [csr_pkg::XLEN-1:0]        csr_wdata_o,

    // writeback toward regfile
    output logic                           wb_valid_o,
    input  logic                           wb_ready_i,
    output logic [csr_pkg::REG_ADDR_W-1:0]  wb_rd_o,
    output logic [csr_pkg::XLEN-1:0]        wb_data_o,
    output logic [csr_pkg::COMMIT_ID_W-1:0] wb_commit_id_o
);

    import csr_pkg::*;

    logic                   stg_csr_we;  // pending csr write
    logic                   stg_wb;      // pending writeback item
    logic [CSR_ADDR_W-1:0]  stg_waddr;
    logic [XLEN-1:0]        stg_wdata;   // already masked
    logic [REG_ADDR_W-1:0]  stg_rd;
    logic [XLEN-1:0]        stg_old;
    logic [COMMIT_ID_W-1:0] stg_cid;

    logic            stg_rel;     // stage empties this edge
    logic            accept;
    logic            bypass_hit;
    logic [XLEN-1:0] old_val;
    logic [XLEN-1:0] new_val;
    logic [XLEN-1:0] wmask;
    logic            op_wr;       // op encoding asks for a write
    logic            csr_we_nxt;
    logic            wb_nxt;

    // stage frees when it has no item or the consumer takes it
    assign stg_rel     = ~stg_wb | wb_ready_i;
    assign req_ready_o = stg_rel;
    assign accept      = req_valid_i & stg_rel;

    assign csr_raddr_o = req_csr_addr_i;  // read port follows issue

    // pending write not yet in the regfile, forward it
    assign bypass_hit = stg_csr_we & (stg_waddr == req_csr_addr_i);
    assign old_val    = bypass_hit ? stg_wdata : csr_rdata_i;

    always_comb begin
        op_wr   = 1'b1;
        new_val = old_val;
        case (req_op_i)
            CSR_RW:  new_val = req_op1_i;
            CSR_RS:  new_val = old_val | req_op1_i;
            CSR_RC:  new_val = old_val & ~req_op1_i;
            default: op_wr = 1'b0;  // encoding 3
        endcase
    end

    // read only / unknown csr gets a zero mask and no write,
    // so the bypass never forwards a value the regfile would drop
    assign wmask      = csr_wmask(req_csr_addr_i);
    assign csr_we_nxt = op_wr & ~int_assert_i & (|wmask);
    assign wb_nxt     = req_rd_we_i & ~int_assert_i;

    // control half of the output stage
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stg_csr_we <= 1'b0;
            stg_wb     <= 1'b0;
        end else if (stg_rel) begin
            stg_csr_we <= accept & csr_we_nxt;  // empty when nothing accepted
            stg_wb     <= accept & wb_nxt;
        end
    end

    // payload half, only meaningful with a flag set
    always_ff @(posedge clk) begin
        if (accept) begin
            stg_waddr <= req_csr_addr_i;
            stg_wdata <= new_val & wmask;  // same value the regfile will hold
            stg_rd    <= req_rd_i;
            stg_old   <= old_val;
            stg_cid   <= req_commit_id_i;
        end
    end

    // commit lands on the release edge, once
    assign csr_we_o    = stg_csr_we & stg_rel;
    assign csr_waddr_o = stg_waddr;
    assign csr_wdata_o = stg_wdata;

    assign wb_valid_o     = stg_wb;
    assign wb_rd_o        = stg_rd;
    assign wb_data_o      = stg_old;  // csr value before the write
    assign wb_commit_id_o = stg_cid;

endmodule

//--- tests/tb_csr_subsys.sv
module tb_csr_subsys;

    timeunit 1ns;
    timeprecision 1ps;

    import csr_pkg::*;

    localparam logic [CSR_ADDR_W-1:0] UNKNOWN_ADDR = 12'h7C0;  // not implemented
    localparam logic [XLEN-1:0]       HART         = 32'd5;
    localparam int                    TIMEOUT      = 200;     // cycles per wait

    logic                   clk;
    logic                   arst_n_i;
    logic                   req_valid_i;
    logic                   req_ready_o;
    csr_op_e                req_op_i;
    logic [XLEN-1:0]        req_op1_i;
    logic [CSR_ADDR_W-1:0]  req_csr_addr_i;
    logic [REG_ADDR_W-1:0]  req_rd_i;
    logic                   req_rd_we_i;
    logic [COMMIT_ID_W-1:0] req_commit_id_i;
    logic                   int_assert_i;
    logic                   wb_valid_o;
    logic                   wb_ready_i;
    logic [REG_ADDR_W-1:0]  wb_rd_o;
    logic [XLEN-1:0]        wb_data_o;
    logic [COMMIT_ID_W-1:0] wb_commit_id_o;

    logic [31:0]            rng_state;
    logic [XLEN-1:0]        model_regs [6];  // mstatus mie mtvec mscratch mepc mcause
    logic [REG_ADDR_W-1:0]  exp_rd_q [$];
    logic [XLEN-1:0]        exp_data_q [$];
    logic [COMMIT_ID_W-1:0] exp_cid_q [$];
    logic [COMMIT_ID_W-1:0] next_cid;
    int                     errors;
    int                     checks;
    int                     tests_run;
    int                     test_start;
    bit                     wb_random;       // random wb_ready_i when set
    bit                     accepted;        // handshake seen on last rising edge
    bit                     wb_due;          // wb_valid_o must rise next edge
    bit                     held;            // writeback stalled on last edge
    logic [REG_ADDR_W-1:0]  held_rd;
    logic [XLEN-1:0]        held_data;
    logic [COMMIT_ID_W-1:0] held_cid;

    csr_subsys_top #(
        .HART_ID (HART)
    ) dut0 (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .req_op_i        (req_op_i),
        .req_op1_i       (req_op1_i),
        .req_csr_addr_i  (req_csr_addr_i),
        .req_rd_i        (req_rd_i),
        .req_rd_we_i     (req_rd_we_i),
        .req_commit_id_i (req_commit_id_i),
        .int_assert_i    (int_assert_i),
        .wb_valid_o      (wb_valid_o),
        .wb_ready_i      (wb_ready_i),
        .wb_rd_o         (wb_rd_o),
        .wb_data_o       (wb_data_o),
        .wb_commit_id_o  (wb_commit_id_o)
    );

    always #4 clk = ~clk;  // 8 ns period

    // lcg with numerical recipes constants
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r[31:8]) % n;  // low bits of an lcg are weak
    endfunction

    // seven csrs and one hole
    function automatic logic [CSR_ADDR_W-1:0] addr_at(input int i);
        case (i)
            0:       return CSR_MSTATUS;
            1:       return CSR_MIE;
            2:       return CSR_MTVEC;
            3:       return CSR_MSCRATCH;
            4:       return CSR_MEPC;
            5:       return CSR_MCAUSE;
            6:       return CSR_MHARTID;
            default: return UNKNOWN_ADDR;
        endcase
    endfunction

    function automatic int model_slot(input logic [CSR_ADDR_W-1:0] addr);
        for (int i = 0; i < 6; i++) begin
            if (addr == addr_at(i)) begin
                return i;
            end
        end
        return -1;  // mhartid and unknown have no storage
    endfunction

    function automatic logic [XLEN-1:0] wmask_of(input int slot);
        case (slot)
            0:       return 32'h0000_1888;  // mstatus keeps mie mpie mpp
            2:       return 32'hFFFF_FFFC;  // mtvec mode bits stay 0
            4:       return 32'hFFFF_FFFE;  // mepc bit 0 stays 0
            default: return 32'hFFFF_FFFF;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] model_read(input logic [CSR_ADDR_W-1:0] addr);
        int slot;
        slot = model_slot(addr);
        if (slot >= 0) begin
            return model_regs[slot];
        end
        return (addr == CSR_MHARTID) ? HART : '0;
    endfunction

    task automatic check_val(input string name, input logic [XLEN-1:0] exp_v,
                             input logic [XLEN-1:0] got_v);
        checks++;
        assert (got_v === exp_v) else begin
            $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, exp_v, got_v);
            errors++;
        end
    endtask

    // sequential model applied in acceptance order
    task automatic model_accept();
        int              slot;
        logic [XLEN-1:0] old_v;
        logic [XLEN-1:0] new_v;
        logic [XLEN-1:0] mask;
        slot  = model_slot(req_csr_addr_i);
        old_v = model_read(req_csr_addr_i);
        if (!int_assert_i && slot >= 0 && req_op_i != csr_op_e'(2'b11)) begin
            case (req_op_i)
                CSR_RW:  new_v = req_op1_i;
                CSR_RS:  new_v = old_v | req_op1_i;
                default: new_v = old_v & ~req_op1_i;  // clear
            endcase
            mask             = wmask_of(slot);
            model_regs[slot] = (old_v & ~mask) | (new_v & mask);
        end
        if (req_rd_we_i && !int_assert_i) begin
            exp_rd_q.push_back(req_rd_i);
            exp_data_q.push_back(old_v);  // old value goes to rd
            exp_cid_q.push_back(req_commit_id_i);
        end
    endtask

    // monitor and scoreboard sample values before this edge's updates
    always @(posedge clk) begin
        if (arst_n_i) begin
            if (wb_due) begin
                check_val("wb_valid_o latency", 1, XLEN'(wb_valid_o));
            end
            if (held) begin  // stalled item must not move
                check_val("wb_valid_o held", 1, XLEN'(wb_valid_o));
                check_val("wb_rd_o held", XLEN'(held_rd), XLEN'(wb_rd_o));
                check_val("wb_data_o held", held_data, wb_data_o);
                check_val("wb_commit_id_o held", XLEN'(held_cid), XLEN'(wb_commit_id_o));
            end
            // ready only drops while an item waits for a consumer
            check_val("req_ready_o", XLEN'(!(wb_valid_o && !wb_ready_i)), XLEN'(req_ready_o));
            if (wb_valid_o && wb_ready_i) begin
                checks++;
                assert (exp_rd_q.size() > 0) else begin
                    $display("writeback at %0t ns with no instruction left to retire", $time);
                    errors++;
                end
                if (exp_rd_q.size() > 0) begin
                    check_val("wb_rd_o", XLEN'(exp_rd_q.pop_front()), XLEN'(wb_rd_o));
                    check_val("wb_data_o", exp_data_q.pop_front(), wb_data_o);
                    check_val("wb_commit_id_o", XLEN'(exp_cid_q.pop_front()),
                              XLEN'(wb_commit_id_o));
                end
            end
            held      = wb_valid_o && !wb_ready_i;
            held_rd   = wb_rd_o;
            held_data = wb_data_o;
            held_cid  = wb_commit_id_o;
            accepted  = req_valid_i && req_ready_o;
            wb_due    = accepted && req_rd_we_i && !int_assert_i;
            if (accepted) begin
                model_accept();
            end
        end
    end

    task automatic drive_wb_ready();
        wb_ready_i = wb_random ? (rand_below(3) != 0) : 1'b1;  // low a third of the time
    endtask

    // starts on a falling edge and returns on the one after acceptance
    task automatic issue_instr(input csr_op_e op, input logic [XLEN-1:0] op1,
                               input logic [CSR_ADDR_W-1:0] addr, input logic rd_we,
                               input logic intr);
        int waited;
        bit done;
        req_valid_i     = 1'b1;
        req_op_i        = op;
        req_op1_i       = op1;
        req_csr_addr_i  = addr;
        req_rd_i        = REG_ADDR_W'(rand_below(32));
        req_rd_we_i     = rd_we;
        req_commit_id_i = next_cid;
        int_assert_i    = intr;
        drive_wb_ready();
        waited = 0;
        done   = 0;
        while (!done) begin
            @(posedge clk);
            @(negedge clk);
            if (accepted) begin
                done = 1;
            end else if (waited >= TIMEOUT) begin
                $display("timeout at %0t ns: instruction never accepted", $time);
                errors++;
                done = 1;
            end else begin
                waited++;
                drive_wb_ready();
            end
        end
        next_cid++;
        req_valid_i  = 1'b0;
        int_assert_i = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        req_valid_i = 1'b0;
        repeat (n) begin
            @(negedge clk);
            drive_wb_ready();
        end
    endtask

    // let every expected writeback retire and expect an empty stage after
    task automatic drain_writebacks();
        int waited;
        waited     = 0;
        wb_ready_i = 1'b1;
        while (exp_rd_q.size() > 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_rd_q.size() > 0) begin
            $display("timeout at %0t ns: %0d writebacks never arrived", $time, exp_rd_q.size());
            errors++;
        end
        check_val("wb_valid_o after drain", 0, XLEN'(wb_valid_o));
    endtask

    // addr_sel below zero picks a random address per instruction
    task automatic run_random(input int count, input bit gaps, input bit kills,
                              input int addr_sel);
        csr_op_e         op;
        logic [XLEN-1:0] op1;
        for (int i = 0; i < count; i++) begin
            op  = (rand_below(8) == 0) ? csr_op_e'(2'b11) : csr_op_e'(2'(rand_below(3)));
            op1 = (rand_below(4) == 0) ? '0 : next_rand();
            issue_instr(op, op1, addr_at(addr_sel < 0 ? rand_below(8) : addr_sel),
                        rand_below(4) != 0, kills && rand_below(8) == 0);
            if (gaps && rand_below(3) == 0) begin
                idle_cycles(1 + rand_below(3));
            end
        end
        drain_writebacks();
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == test_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_start);
        end
        test_start = errors;
    endtask

    initial begin
        rng_state       = 32'd57126;
        errors          = 0;
        checks          = 0;
        tests_run       = 0;
        test_start      = 0;
        next_cid        = '0;
        wb_random       = 0;
        accepted        = 0;
        wb_due          = 0;
        held            = 0;
        clk             = 1'b0;
        arst_n_i        = 1'b0;
        req_valid_i     = 1'b0;
        req_op_i        = CSR_RW;
        req_op1_i       = '0;
        req_csr_addr_i  = '0;
        req_rd_i        = '0;
        req_rd_we_i     = 1'b0;
        req_commit_id_i = '0;
        int_assert_i    = 1'b0;
        wb_ready_i      = 1'b0;
        for (int i = 0; i < 6; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;

        check_val("wb_valid_o after reset", 0, XLEN'(wb_valid_o));
        check_val("req_ready_o after reset", 1, XLEN'(req_ready_o));
        for (int i = 0; i < 8; i++) begin
            issue_instr(CSR_RS, '0, addr_at(i), 1'b1, 1'b0);  // plain reads
        end
        drain_writebacks();
        report_test("reset state");

        run_random(200, 1, 0, -1);
        report_test("operation semantics");

        for (int a = 0; a < 7; a++) begin
            run_random(12, 0, 0, a);  // same address without gaps
        end
        report_test("back-to-back bypass");

        wb_random = 1;
        run_random(200, 1, 0, -1);
        wb_random = 0;
        report_test("back-pressure");

        issue_instr(CSR_RW, 32'h1234_5678, CSR_MSCRATCH, 1'b0, 1'b0);
        issue_instr(CSR_RW, 32'hDEAD_BEEF, CSR_MSCRATCH, 1'b1, 1'b1);  // killed
        issue_instr(CSR_RW, '1, CSR_MHARTID, 1'b0, 1'b0);
        issue_instr(CSR_RW, '1, UNKNOWN_ADDR, 1'b0, 1'b0);
        issue_instr(CSR_RS, '0, CSR_MSCRATCH, 1'b1, 1'b0);
        issue_instr(CSR_RS, '0, CSR_MHARTID, 1'b1, 1'b0);
        issue_instr(CSR_RS, '0, UNKNOWN_ADDR, 1'b1, 1'b0);
        drain_writebacks();
        wb_random = 1;
        run_random(150, 1, 1, -1);
        wb_random = 0;
        report_test("interrupt kill and no-write");

        run_random(60, 1, 0, -1);  // wb_due check covers every accept
        report_test("latency");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
